// File: hw/lsu_settings.svh
/* Width and depth constants shared by the data-cache lookup slice */

`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Request fields
`define ADDR_WIDTH      32
`define TAG_WIDTH       6

// Cache geometry: 32-byte lines, 16 sets, 2 ways
`define DC_LINE_WIDTH   5
`define DC_INDEX_WIDTH  4
`define DC_WAY_WIDTH    1
`define DC_TAG_WIDTH    23

// Outstanding misses held by the MSHQ
`define MSHQ_DEPTH      4

`endif

// File: hw/lsu_pkg.sv
/* Load/store unit operation encodings */

`default_nettype none

package lsu_pkg;

    // Loads in the low half, stores above
    typedef enum logic [2:0] {
        LSU_LB = 3'd0,
        LSU_LH = 3'd1,
        LSU_LW = 3'd2,
        LSU_SB = 3'd3,
        LSU_SH = 3'd4,
        LSU_SW = 3'd5
    } lsu_func_t;

endpackage

`default_nettype wire

// File: hw/dc_pkg.sv
/* Cache structure types: tag memory entry and MSHQ entry */

`default_nettype none

`include "lsu_settings.svh"

package dc_pkg;

    import lsu_pkg::*;

    // One way of one set
    typedef struct packed {
        logic                       valid;
        logic [`DC_TAG_WIDTH-1:0]   tag;
    } dc_tag_entry_t;

    // Outstanding miss, kept as the original request
    typedef struct packed {
        lsu_func_t                  lsu_func;
        logic [`ADDR_WIDTH-1:0]     addr;
        logic [`TAG_WIDTH-1:0]      tag;
    } mshq_entry_t;

endpackage

`default_nettype wire

// File: hw/lsu_ifs.sv
/* Lookup stage to tag memory interface, lookup stage to MSHQ interface */

`default_nettype none

`include "lsu_settings.svh"

interface dc_tag_if;

    logic [`DC_INDEX_WIDTH-1:0] index;
    logic [`DC_TAG_WIDTH-1:0]   tag;
    logic                       hit;
    logic [`DC_WAY_WIDTH-1:0]   way_addr;

    modport lookup (output index, output tag, input hit, input way_addr);
    modport tagmem (input index, input tag, output hit, output way_addr);

endinterface

interface mshq_if;

    import lsu_pkg::*;

    // en is a single-cycle strobe per miss
    logic                       en;
    lsu_func_t                  lsu_func;
    logic [`ADDR_WIDTH-1:0]     addr;
    logic [`TAG_WIDTH-1:0]      tag;

    modport src (output en, output lsu_func, output addr, output tag);
    modport dst (input en, input lsu_func, input addr, input tag);

endinterface

`default_nettype wire

// File: hw/lsu_hit.sv
/* Data-cache tag lookup stage
   Splits the address for the tag memory, forwards the hit result
   and raises a miss towards the MSHQ */

`default_nettype none

`include "lsu_settings.svh"

module lsu_hit (
    // Request from the previous LSU stage
    input  lsu_pkg::lsu_func_t              i_lsu_func,
    input  logic [`ADDR_WIDTH-1:0]          i_addr,
    input  logic [`TAG_WIDTH-1:0]           i_tag,
    input  logic                            i_valid,

    // Result to the next LSU stage
    output lsu_pkg::lsu_func_t              o_lsu_func,
    output logic [`ADDR_WIDTH-1:0]          o_addr,
    output logic [`TAG_WIDTH-1:0]           o_tag,
    output logic [`DC_WAY_WIDTH-1:0]        o_way_addr,
    output logic                            o_hit,
    output logic                            o_valid,

    dc_tag_if.lookup                        tag_port,
    mshq_if.src                             mshq_port
);

    // Index sits just above the line offset, tag takes the remaining top bits
    assign tag_port.index   = i_addr[`DC_INDEX_WIDTH+`DC_LINE_WIDTH-1:`DC_LINE_WIDTH];
    assign tag_port.tag     = i_addr[`ADDR_WIDTH-1:`ADDR_WIDTH-`DC_TAG_WIDTH];

    // Misses go to the queue unchanged
    assign mshq_port.en         = i_valid && !tag_port.hit;
    assign mshq_port.lsu_func   = i_lsu_func;
    assign mshq_port.addr       = i_addr;
    assign mshq_port.tag        = i_tag;

    // Same-cycle result for the next stage
    assign o_lsu_func   = i_lsu_func;
    assign o_addr       = i_addr;
    assign o_tag        = i_tag;
    assign o_way_addr   = tag_port.way_addr;
    assign o_hit        = tag_port.hit;
    assign o_valid      = i_valid;

endmodule

`default_nettype wire

// File: hw/dc_tag_mem.sv
/* Two-way data-cache tag store with valid bits
   Combinational lookup, fill into an invalid way or the round-robin victim */

`default_nettype none

`include "lsu_settings.svh"

module dc_tag_mem (
    input  logic                            clk,
    input  logic                            i_rst_n,

    // Line fill from the MSHQ
    input  logic                            i_fill_en,
    input  logic [`DC_INDEX_WIDTH-1:0]      i_fill_index,
    input  logic [`DC_TAG_WIDTH-1:0]        i_fill_tag,

    dc_tag_if.tagmem                        lookup_port
);

    import dc_pkg::*;

    localparam int WAY_W    = `DC_WAY_WIDTH;
    localparam int NUM_SETS = 1 << `DC_INDEX_WIDTH;
    localparam int NUM_WAYS = 1 << `DC_WAY_WIDTH;

    dc_tag_entry_t          tag_array [NUM_SETS][NUM_WAYS];
    logic [WAY_W-1:0]       rr_way    [NUM_SETS];

    logic                   rd_hit;
    logic [WAY_W-1:0]       rd_way;
    logic                   fill_present;
    logic                   inv_found;
    logic [WAY_W-1:0]       victim_way;

    // Compare all ways, walk downwards so the lowest match wins
    always_comb begin
        rd_hit = 1'b0;
        rd_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (tag_array[lookup_port.index][w].valid &&
                tag_array[lookup_port.index][w].tag == lookup_port.tag) begin
                rd_hit = 1'b1;
                rd_way = WAY_W'(w);
            end
        end
    end

    assign lookup_port.hit      = rd_hit;
    assign lookup_port.way_addr = rd_way;

    // Victim selection: lowest invalid way, else the set's round-robin way
    always_comb begin
        fill_present = 1'b0;
        inv_found    = 1'b0;
        victim_way   = rr_way[i_fill_index];
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (tag_array[i_fill_index][w].valid &&
                tag_array[i_fill_index][w].tag == i_fill_tag) begin
                fill_present = 1'b1;
            end
            if (!tag_array[i_fill_index][w].valid) begin
                inv_found  = 1'b1;
                victim_way = WAY_W'(w);
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                rr_way[s] <= '0;
                for (int w = 0; w < NUM_WAYS; w++) begin
                    tag_array[s][w] <= '0;
                end
            end
        end else if (i_fill_en && !fill_present) begin
            tag_array[i_fill_index][victim_way] <= '{valid: 1'b1, tag: i_fill_tag};
            // Only an eviction advances the pointer
            if (!inv_found) begin
                rr_way[i_fill_index] <= rr_way[i_fill_index] + WAY_W'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/lsu_mshq.sv
/* Miss-handling queue
   Circular FIFO of misses, oldest entry offered to memory as a level request */

`default_nettype none

`include "lsu_settings.svh"

module lsu_mshq #(
    parameter int DEPTH = `MSHQ_DEPTH
) (
    input  logic                            clk,
    input  logic                            i_rst_n,
    input  logic                            i_mem_done,

    mshq_if.dst                             enq_port,

    // Memory request, head of queue
    output logic                            o_mem_req,
    output lsu_pkg::lsu_func_t              o_mem_lsu_func,
    output logic [`ADDR_WIDTH-1:0]          o_mem_addr,
    output logic [`TAG_WIDTH-1:0]           o_mem_tag,
    output logic                            o_full,

    // Tag fill towards the tag memory
    output logic                            o_fill_en,
    output logic [`DC_INDEX_WIDTH-1:0]      o_fill_index,
    output logic [`DC_TAG_WIDTH-1:0]        o_fill_tag
);

    import dc_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = PTR_W + 1;

    mshq_entry_t            queue [DEPTH];
    mshq_entry_t            head_entry;
    logic [PTR_W-1:0]       head;
    logic [PTR_W-1:0]       tail;
    logic [CNT_W-1:0]       count;
    logic                   push;
    logic                   pop;

    // Wrap explicitly so any depth works
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    assign o_full = (count == CNT_W'(DEPTH));
    assign push   = enq_port.en && !o_full;
    assign pop    = i_mem_done && (count != '0);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) tail <= next_ptr(tail);
            if (pop)  head <= next_ptr(head);
            if (push && !pop) begin
                count <= count + CNT_W'(1);
            end else if (pop && !push) begin
                count <= count - CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            queue[tail] <= '{lsu_func: enq_port.lsu_func,
                             addr:     enq_port.addr,
                             tag:      enq_port.tag};
        end
    end

    assign head_entry     = queue[head];
    assign o_mem_req      = (count != '0);
    assign o_mem_lsu_func = head_entry.lsu_func;
    assign o_mem_addr     = head_entry.addr;
    assign o_mem_tag      = head_entry.tag;

    // Done both pops the head and fills its line
    assign o_fill_en    = i_mem_done;
    assign o_fill_index = head_entry.addr[`DC_INDEX_WIDTH+`DC_LINE_WIDTH-1:`DC_LINE_WIDTH];
    assign o_fill_tag   = head_entry.addr[`ADDR_WIDTH-1:`ADDR_WIDTH-`DC_TAG_WIDTH];

endmodule

`default_nettype wire

// File: hw/lsu_dcache_top.sv
/* Data-cache lookup slice top level
   Lookup stage, tag memory and MSHQ */

`default_nettype none

`include "lsu_settings.svh"

module lsu_dcache_top (
    input  logic                            clk,
    input  logic                            i_rst_n,

    // Request from the previous LSU stage
    input  lsu_pkg::lsu_func_t              i_lsu_func,
    input  logic [`ADDR_WIDTH-1:0]          i_addr,
    input  logic [`TAG_WIDTH-1:0]           i_tag,
    input  logic                            i_valid,

    // Result to the next LSU stage
    output lsu_pkg::lsu_func_t              o_lsu_func,
    output logic [`ADDR_WIDTH-1:0]          o_addr,
    output logic [`TAG_WIDTH-1:0]           o_tag,
    output logic [`DC_WAY_WIDTH-1:0]        o_way_addr,
    output logic                            o_hit,
    output logic                            o_valid,

    // Memory side
    output logic                            o_mem_req,
    output lsu_pkg::lsu_func_t              o_mem_lsu_func,
    output logic [`ADDR_WIDTH-1:0]          o_mem_addr,
    output logic [`TAG_WIDTH-1:0]           o_mem_tag,
    input  logic                            i_mem_done,
    output logic                            o_mshq_full
);

    logic                           fill_en;
    logic [`DC_INDEX_WIDTH-1:0]     fill_index;
    logic [`DC_TAG_WIDTH-1:0]       fill_tag;

    dc_tag_if tag_bus ();
    mshq_if   miss_bus ();

    lsu_hit u_lsu_hit (
        .i_lsu_func (i_lsu_func),
        .i_addr     (i_addr),
        .i_tag      (i_tag),
        .i_valid    (i_valid),
        .o_lsu_func (o_lsu_func),
        .o_addr     (o_addr),
        .o_tag      (o_tag),
        .o_way_addr (o_way_addr),
        .o_hit      (o_hit),
        .o_valid    (o_valid),
        .tag_port   (tag_bus.lookup),
        .mshq_port  (miss_bus.src)
    );

    dc_tag_mem u_dc_tag_mem (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_fill_en    (fill_en),
        .i_fill_index (fill_index),
        .i_fill_tag   (fill_tag),
        .lookup_port  (tag_bus.tagmem)
    );

    lsu_mshq #(
        .DEPTH (`MSHQ_DEPTH)
    ) u_lsu_mshq (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_mem_done     (i_mem_done),
        .enq_port       (miss_bus.dst),
        .o_mem_req      (o_mem_req),
        .o_mem_lsu_func (o_mem_lsu_func),
        .o_mem_addr     (o_mem_addr),
        .o_mem_tag      (o_mem_tag),
        .o_full         (o_mshq_full),
        .o_fill_en      (fill_en),
        .o_fill_index   (fill_index),
        .o_fill_tag     (fill_tag)
    );

endmodule

`default_nettype wire

// File: tb/lsu_dcache_props.sv
/* Concurrent assertions on the MSHQ request level, entry count and done pulse
   Bound into every lsu_mshq instance */

`default_nettype none

module lsu_dcache_props #(
    parameter int DEPTH = 4,
    parameter int CNT_W = 3
) (
    input logic             clk,
    input logic             i_rst_n,
    input logic             i_push,
    input logic             i_mem_req,
    input logic             i_mem_done,
    input logic [CNT_W-1:0] i_count
);

    timeunit 1ns;
    timeprecision 1ps;

    logic                   shadow_pop;
    logic [CNT_W-1:0]       shadow_count;

    assign shadow_pop = i_mem_done && (shadow_count != '0);

    // Entry count rebuilt from accepted misses and done pulses
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            shadow_count <= '0;
        end else if (i_push && !shadow_pop) begin
            shadow_count <= shadow_count + CNT_W'(1);
        end else if (shadow_pop && !i_push) begin
            shadow_count <= shadow_count - CNT_W'(1);
        end
    end

    // Request level means the queue holds at least one miss
    req_matches_count: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_mem_req == (shadow_count != '0))
        else $error("MSHQ request level does not match its entry count");

    count_in_range: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_count <= CNT_W'(DEPTH))
        else $error("MSHQ entry count above its depth");

    done_needs_req: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_mem_done |-> i_mem_req)
        else $error("memory done pulse without a pending request");

endmodule

bind lsu_mshq lsu_dcache_props #(
    .DEPTH (DEPTH),
    .CNT_W (CNT_W)
) u_mshq_props (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_push     (push),
    .i_mem_req  (o_mem_req),
    .i_mem_done (i_mem_done),
    .i_count    (count)
);

`default_nettype wire

// File: tb/lsu_dcache_tb.sv
/* Directed testbench for the data-cache lookup slice
   Tag reference model, expected memory request queue and a cycle limit */

`default_nettype none

`include "lsu_settings.svh"

module lsu_dcache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import lsu_pkg::*;

    // The five tests need under 200 cycles, the limit gives a tenfold margin
    localparam int MAX_CYCLES = 2000;
    localparam int NUM_SETS   = 16;

    logic                       clk;
    logic                       rst_n;
    lsu_func_t                  req_func;
    logic [`ADDR_WIDTH-1:0]     req_addr;
    logic [`TAG_WIDTH-1:0]      req_tag;
    logic                       req_valid;
    logic                       mem_done;

    lsu_func_t                  res_func;
    logic [`ADDR_WIDTH-1:0]     res_addr;
    logic [`TAG_WIDTH-1:0]      res_tag;
    logic [`DC_WAY_WIDTH-1:0]   res_way;
    logic                       res_hit;
    logic                       res_valid;
    logic                       mem_req;
    lsu_func_t                  mem_func;
    logic [`ADDR_WIDTH-1:0]     mem_addr;
    logic [`TAG_WIDTH-1:0]      mem_tag;
    logic                       mshq_full;

    // Reference tag store, two ways per set
    logic                       ref_valid [NUM_SETS][2];
    logic [22:0]                ref_tag   [NUM_SETS][2];
    logic                       ref_rr    [NUM_SETS];

    // Misses that memory should see, oldest first
    logic [31:0]                exp_addr_q [$];
    lsu_func_t                  exp_func_q [$];
    logic [5:0]                 exp_tag_q  [$];

    integer                     seed;
    int                         err_count;
    int                         tests_run;
    int                         tests_failed;
    int                         cycles = 0;

    lsu_dcache_top u_lsu_dcache_top (
        .clk            (clk),
        .i_rst_n        (rst_n),
        .i_lsu_func     (req_func),
        .i_addr         (req_addr),
        .i_tag          (req_tag),
        .i_valid        (req_valid),
        .o_lsu_func     (res_func),
        .o_addr         (res_addr),
        .o_tag          (res_tag),
        .o_way_addr     (res_way),
        .o_hit          (res_hit),
        .o_valid        (res_valid),
        .o_mem_req      (mem_req),
        .o_mem_lsu_func (mem_func),
        .o_mem_addr     (mem_addr),
        .o_mem_tag      (mem_tag),
        .i_mem_done     (mem_done),
        .o_mshq_full    (mshq_full)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Cache tag in bits 31..9, set index in bits 8..5
    function automatic logic [31:0] line_addr(input logic [22:0] t, input logic [3:0] s,
                                              input logic [4:0] off);
        return {t, s, off};
    endfunction

    function automatic lsu_func_t random_func();
        return lsu_func_t'(3'($unsigned($random(seed)) % 6));
    endfunction

    function automatic void model_hit(input logic [31:0] a, output logic hit, output logic way);
        hit = 1'b0;
        way = 1'b0;
        for (int w = 1; w >= 0; w--) begin
            if (ref_valid[a[8:5]][w] && ref_tag[a[8:5]][w] == a[31:9]) begin
                hit = 1'b1;
                way = w[0];
            end
        end
    endfunction

    // Invalid way first, else the round-robin way, which then flips
    function automatic void model_fill(input logic [31:0] a);
        logic [3:0] s;
        logic       present;
        logic       w;
        s = a[8:5];
        model_hit(a, present, w);
        if (!present) begin
            if (!ref_valid[s][0]) begin
                w = 1'b0;
            end else if (!ref_valid[s][1]) begin
                w = 1'b1;
            end else begin
                w = ref_rr[s];
                ref_rr[s] = ~ref_rr[s];
            end
            ref_valid[s][w] = 1'b1;
            ref_tag[s][w] = a[31:9];
        end
    endfunction

    task automatic check(input logic cond, input string msg);
        assert (cond) else begin
            $display("[ERROR] %0t ns: %s", $time, msg);
            err_count++;
        end
    endtask

    task automatic report(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("[ok]     %s", name);
        end else begin
            tests_failed++;
            $display("[failed] %s, %0d errors", name, err_count - errs_before);
        end
    endtask

    // One request for one cycle, checked against the model while it is held
    task automatic lookup(input logic valid, input lsu_func_t func, input logic [31:0] a,
                          input logic [5:0] t, output logic hit, output logic way);
        logic exp_hit;
        logic exp_way;
        @(posedge clk);
        req_valid <= valid;
        req_func  <= func;
        req_addr  <= a;
        req_tag   <= t;
        @(negedge clk);
        model_hit(a, exp_hit, exp_way);
        check(res_valid === valid, "o_valid does not follow i_valid");
        check(res_func === func && res_addr === a && res_tag === t,
              $sformatf("request not passed through for address %h", a));
        check(res_hit === exp_hit,
              $sformatf("o_hit %b for address %h, expected %b", res_hit, a, exp_hit));
        if (exp_hit) begin
            check(res_way === exp_way,
                  $sformatf("o_way_addr %b for address %h, expected %b", res_way, a, exp_way));
        end
        hit = res_hit;
        way = res_way;
        if (valid && !exp_hit && exp_addr_q.size() < `MSHQ_DEPTH) begin
            exp_addr_q.push_back(a);
            exp_func_q.push_back(func);
            exp_tag_q.push_back(t);
        end
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic check_head();
        check(mem_req === 1'b1, "o_mem_req low with a miss outstanding");
        check(mem_func === exp_func_q[0] && mem_tag === exp_tag_q[0],
              "memory request function or tag differs from the oldest miss");
        check(mem_addr === exp_addr_q[0],
              $sformatf("o_mem_addr %h, expected %h", mem_addr, exp_addr_q[0]));
    endtask

    // Waits for the memory request, answers it with a done pulse
    task automatic complete_miss();
        logic [31:0] a;
        @(negedge clk);
        while (mem_req !== 1'b1) begin
            @(negedge clk);
        end
        if (exp_addr_q.size() == 0) begin
            check(1'b0, "memory request seen with no miss outstanding");
        end else begin
            check_head();
            a = exp_addr_q.pop_front();
            void'(exp_func_q.pop_front());
            void'(exp_tag_q.pop_front());
            @(posedge clk);
            mem_done <= 1'b1;
            @(posedge clk);
            mem_done <= 1'b0;
            model_fill(a);
        end
    endtask

    task automatic test_cold_miss();
        int   e0;
        logic hit;
        logic way;
        e0 = err_count;
        @(negedge clk);
        check(mem_req === 1'b0 && mshq_full === 1'b0, "memory request or full high after reset");
        lookup(1'b1, LSU_LW, line_addr(23'h1, 4'h3, 5'h0), 6'h11, hit, way);
        check(hit === 1'b0, "cold access hit");
        @(negedge clk);
        check_head();
        report("cold miss", e0);
    endtask

    task automatic test_fill_hit();
        int   e0;
        logic hit;
        logic way;
        e0 = err_count;
        complete_miss();
        @(negedge clk);
        check(mem_req === 1'b0, "o_mem_req still high after the done pulse");
        lookup(1'b1, LSU_LW, line_addr(23'h1, 4'h3, 5'h0), 6'h11, hit, way);
        check(hit === 1'b1 && way === 1'b0, "filled line does not hit on way 0");
        lookup(1'b1, random_func(), line_addr(23'h1, 4'h3, 5'h1c), 6'($random(seed)), hit, way);
        check(hit === 1'b1 && way === 1'b0, "second address in the line does not hit");
        report("fill then hit", e0);
    endtask

    task automatic test_two_ways();
        int   e0;
        logic hit;
        logic way;
        e0 = err_count;
        lookup(1'b1, LSU_SW, line_addr(23'h2, 4'h3, 5'h8), 6'h22, hit, way);
        check(hit === 1'b0, "second line hit before its fill");
        complete_miss();
        lookup(1'b1, LSU_LB, line_addr(23'h2, 4'h3, 5'h0), 6'h23, hit, way);
        check(hit === 1'b1 && way === 1'b1, "second line does not hit on way 1");
        lookup(1'b1, LSU_LH, line_addr(23'h1, 4'h3, 5'h0), 6'h24, hit, way);
        check(hit === 1'b1 && way === 1'b0, "first line lost from way 0");
        report("two ways", e0);
    endtask

    task automatic test_round_robin();
        int   e0;
        logic hit;
        logic way;
        e0 = err_count;
        lookup(1'b1, LSU_LW, line_addr(23'h3, 4'h3, 5'h0), 6'h31, hit, way);
        complete_miss();
        lookup(1'b1, LSU_LW, line_addr(23'h3, 4'h3, 5'h0), 6'h32, hit, way);
        check(hit === 1'b1 && way === 1'b0, "third line not filled into way 0");
        // Probe only, so the evicted line is not queued again
        lookup(1'b0, LSU_LW, line_addr(23'h1, 4'h3, 5'h0), 6'h33, hit, way);
        check(hit === 1'b0, "evicted first line still hits");
        lookup(1'b1, LSU_SB, line_addr(23'h4, 4'h3, 5'h10), 6'h34, hit, way);
        complete_miss();
        lookup(1'b1, LSU_LW, line_addr(23'h4, 4'h3, 5'h0), 6'h35, hit, way);
        check(hit === 1'b1 && way === 1'b1, "fourth line not filled into way 1");
        report("round-robin eviction", e0);
    endtask

    task automatic test_queue_full();
        int          e0;
        logic        hit;
        logic        way;
        logic [31:0] lines [4];
        logic [31:0] extra;
        e0 = err_count;
        for (int i = 0; i < 4; i++) begin
            lines[i] = line_addr(23'($random(seed)), 4'(8 + i), 5'($random(seed)));
            lookup(1'b1, random_func(), lines[i], 6'($random(seed)), hit, way);
            check(hit === 1'b0, "fresh line hit in an empty set");
        end
        @(negedge clk);
        check(mshq_full === 1'b1, "o_mshq_full low with four misses queued");
        extra = line_addr(23'($random(seed)), 4'hc, 5'h0);
        lookup(1'b1, random_func(), extra, 6'($random(seed)), hit, way);
        for (int i = 0; i < 4; i++) begin
            complete_miss();
        end
        @(negedge clk);
        check(mem_req === 1'b0, "miss dropped while full was still requested");
        for (int i = 0; i < 4; i++) begin
            lookup(1'b1, random_func(), lines[i], 6'($random(seed)), hit, way);
            check(hit === 1'b1, $sformatf("filled line %h does not hit", lines[i]));
        end
        lookup(1'b0, LSU_LB, extra, 6'h0, hit, way);
        check(hit === 1'b0, "dropped miss was filled");
        report("queue order and full", e0);
    endtask

    initial begin
        seed         = 32'h4349_7e68;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        clk          = 1'b0;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req_func     = LSU_LB;
        req_addr     = '0;
        req_tag      = '0;
        mem_done     = 1'b0;
        for (int s = 0; s < NUM_SETS; s++) begin
            ref_rr[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
            end
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        test_cold_miss();
        test_fill_hit();
        test_two_ways();
        test_round_robin();
        test_queue_full();

        $display("Summary: %0d tests, %0d failed, %0d check errors",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+hw
hw/lsu_pkg.sv
hw/dc_pkg.sv
hw/lsu_ifs.sv
hw/lsu_hit.sv
hw/dc_tag_mem.sv
hw/lsu_mshq.sv
hw/lsu_dcache_top.sv
tb/lsu_dcache_props.sv
tb/lsu_dcache_tb.sv

// File: run.sh
#!/bin/sh
# Build the data-cache slice testbench with Verilator, run it, check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lsu_dcache_tb -f list.f -o lsu_dcache_sim

./obj_dir/lsu_dcache_sim | tee sim.log

if grep -q "TEST PASS" sim.log; then
    echo "Result: simulation passed"
else
    echo "Result: simulation failed"
    exit 1
fi
